// File: include/seq_macros.svh
`ifndef SEQ_MACROS_SVH
`define SEQ_MACROS_SVH

// top index of the condition bus where xk sits at bit k and bit 0 stays unused
`define SEQ_COND_W 20

// top index of the command bus where yk sits at bit k
`define SEQ_CMD_W 39

// flops between the condition pins and the controller
`define SEQ_SYNC_STAGES 2

`endif

// File: rtl/action_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module action_encoder (
	input  logic             rst,
	input  logic             clk,
	input  seq_pkg::action_e action,
	output seq_pkg::cmd_t    cmd
);

	function automatic seq_pkg::cmd_t cmd_bit(input int unsigned k);
		seq_pkg::cmd_t v;
		v    = '0;
		v[k] = 1'b1;
		return v;
	endfunction

	// bit 0 plus the lines that only the removed region drove
	localparam seq_pkg::cmd_t dropped_mask = cmd_bit(0) | cmd_bit(4) | cmd_bit(30) |
		cmd_bit(31) | cmd_bit(32) | cmd_bit(33);

	seq_pkg::cmd_t pattern;

	always_comb
	begin
		case (action)
			seq_pkg::act_a1:  pattern = cmd_bit(17) | cmd_bit(29) | cmd_bit(34);
			seq_pkg::act_a2:  pattern = cmd_bit(34);
			seq_pkg::act_a3:  pattern = cmd_bit(39);
			seq_pkg::act_a4:  pattern = cmd_bit(36);
			seq_pkg::act_a5:  pattern = cmd_bit(1) | cmd_bit(17) | cmd_bit(19) |
				cmd_bit(29) | cmd_bit(36);
			seq_pkg::act_a6:  pattern = cmd_bit(35) | cmd_bit(37);
			seq_pkg::act_a7:  pattern = cmd_bit(1) | cmd_bit(18) | cmd_bit(25) |
				cmd_bit(35) | cmd_bit(38);
			seq_pkg::act_a8:  pattern = cmd_bit(20);
			seq_pkg::act_a9:  pattern = cmd_bit(25);
			seq_pkg::act_a10: pattern = cmd_bit(24);
			seq_pkg::act_a11: pattern = cmd_bit(8);
			seq_pkg::act_a12: pattern = cmd_bit(2) | cmd_bit(5) | cmd_bit(6) | cmd_bit(8) |
				cmd_bit(11) | cmd_bit(12) | cmd_bit(21);
			seq_pkg::act_a13: pattern = cmd_bit(28);
			seq_pkg::act_a14: pattern = cmd_bit(9) | cmd_bit(35) | cmd_bit(36);
			seq_pkg::act_a15: pattern = cmd_bit(7) | cmd_bit(8);
			seq_pkg::act_a16: pattern = cmd_bit(5);
			seq_pkg::act_a17: pattern = cmd_bit(27);
			seq_pkg::act_a18: pattern = cmd_bit(3) | cmd_bit(26);
			seq_pkg::act_a19: pattern = cmd_bit(6);
			seq_pkg::act_a20: pattern = cmd_bit(10) | cmd_bit(26);
			seq_pkg::act_a21: pattern = cmd_bit(13) | cmd_bit(14) | cmd_bit(15) | cmd_bit(16);
			seq_pkg::act_a22: pattern = cmd_bit(2) | cmd_bit(5) | cmd_bit(6) | cmd_bit(8) |
				cmd_bit(10) | cmd_bit(11) | cmd_bit(12);
			seq_pkg::act_a23: pattern = cmd_bit(22) | cmd_bit(23);
			seq_pkg::act_a24: pattern = cmd_bit(1) | cmd_bit(17);
			default:          pattern = '0;
		endcase
	end

	// commands leave one edge after the controller picks them
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			cmd <= '0;
		else
			cmd <= pattern;
	end

	no_dropped_lines: assert property (@(posedge rst) disable iff (!clk)
		(cmd & dropped_mask) == '0);

endmodule

`default_nettype wire

// File: rtl/cond_sync.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_macros.svh"

module cond_sync (
	input  logic           rst,
	input  logic           clk,
	input  seq_pkg::cond_t cond,
	output seq_pkg::cond_t cond_s
);

	// the controller never reads x2 or x18 so those bits stay out of the chain
	localparam seq_pkg::cond_t used_mask =
		{{(`SEQ_COND_W - 18){1'b1}}, 1'b0, {15{1'b1}}, 1'b0, 2'b10};

	seq_pkg::cond_t sync_q [`SEQ_SYNC_STAGES];

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			for (int i = 0; i < `SEQ_SYNC_STAGES; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			sync_q[0] <= cond & used_mask;
			for (int i = 1; i < `SEQ_SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign cond_s = sync_q[`SEQ_SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: rtl/dispatch_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_decoder (
	input  seq_pkg::cond_t   cond_s,
	output seq_pkg::state_e  next_state,
	output seq_pkg::action_e action
);

	logic x1;
	logic x3;
	logic x7;
	logic x8;
	logic x9;
	logic x10;
	logic x11;
	logic x12;
	logic x13;
	logic x14;
	logic x15;
	logic x16;
	logic x17;
	logic wrap_hit;

	assign x1  = cond_s[1];
	assign x3  = cond_s[3];
	assign x7  = cond_s[7];
	assign x8  = cond_s[8];
	assign x9  = cond_s[9];
	assign x10 = cond_s[10];
	assign x11 = cond_s[11];
	assign x12 = cond_s[12];
	assign x13 = cond_s[13];
	assign x14 = cond_s[14];
	assign x15 = cond_s[15];
	assign x16 = cond_s[16];
	assign x17 = cond_s[17];

	// same test as the wrap-up step, used wherever the tree ends early
	assign wrap_hit = x17 & (x10 | x11);

	// branches toward s9 and s10 keep their commands but fall back to idle
	always_comb
	begin
		next_state = seq_pkg::st_idle;
		action     = seq_pkg::act_none;
		if (x12)
		begin
			if (x14)
			begin
				if (!x13)
				begin
					next_state = seq_pkg::st_s6;
					action     = seq_pkg::act_a11;
				end
				else
				begin
					next_state = seq_pkg::st_wrap;
					action     = x16 ? seq_pkg::act_a9 : seq_pkg::act_a10;
				end
			end
			else if (x15)
			begin
				if (x13 && !x16)
				begin
					next_state = seq_pkg::st_s7;
					action     = seq_pkg::act_a12;
				end
				else
				begin
					next_state = seq_pkg::st_s6;
					action     = seq_pkg::act_a11;
				end
			end
			else if (x13)
			begin
				// x16 decides whether x11 or x10 opens the path to s8
				if (x16 ? x11 : x10)
				begin
					next_state = seq_pkg::st_s8;
					action     = seq_pkg::act_a8;
				end
				else if (wrap_hit)
					action = seq_pkg::act_a13;
			end
			else if (x3)
				action = seq_pkg::act_a14;
			else if (x16 && !x1)
			begin
				next_state = seq_pkg::st_s6;
				action     = seq_pkg::act_a11;
			end
			else
				action = seq_pkg::act_a15;
		end
		else if (x3)
			action = seq_pkg::act_a14;
		else if (!x13)
			action = seq_pkg::act_a15;
		else if (x15 ? (x16 || x9) : (x16 ? x8 : x7))
			action = seq_pkg::act_a15;
		else if (wrap_hit)
			action = seq_pkg::act_a13;
	end

endmodule

`default_nettype wire

// File: rtl/seq_controller.sv
`timescale 1ns/1ns
`default_nettype none

module seq_controller (
	input  logic             rst,
	input  logic             clk,
	input  seq_pkg::cond_t   cond_s,
	output seq_pkg::action_e action
);

	seq_pkg::state_e  state;
	seq_pkg::state_e  next_state;
	seq_pkg::state_e  dec_state;
	seq_pkg::action_e dec_action;
	logic             wrap_hit;

	dispatch_decoder dispatch_decoder_i (
		.cond_s     (cond_s),
		.next_state (dec_state),
		.action     (dec_action)
	);

	assign wrap_hit = cond_s[17] & (cond_s[10] | cond_s[11]);

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state <= seq_pkg::st_idle;
		else
			state <= next_state;
	end

	// bit k of cond_s is condition xk
	always_comb
	begin
		next_state = seq_pkg::st_idle;
		action     = seq_pkg::act_none;
		case (state)
			seq_pkg::st_idle:
			begin
				if (cond_s[6] && cond_s[5])
				begin
					if (cond_s[20])
						action = cond_s[19] ? seq_pkg::act_a1 : seq_pkg::act_a2;
					else
						action = cond_s[19] ? seq_pkg::act_a3 : seq_pkg::act_a4;
				end
				else if (cond_s[6] && cond_s[4])
				begin
					next_state = seq_pkg::st_short;
					action     = seq_pkg::act_a5;
				end
				else if (cond_s[6])
				begin
					next_state = seq_pkg::st_prep;
					action     = seq_pkg::act_a6;
				end
			end
			seq_pkg::st_short:
				action = seq_pkg::act_a7;
			seq_pkg::st_prep:
			begin
				next_state = seq_pkg::st_dispatch;
				action     = seq_pkg::act_a8;
			end
			seq_pkg::st_dispatch:
			begin
				next_state = dec_state;
				action     = dec_action;
			end
			seq_pkg::st_wrap:
			begin
				if (wrap_hit)
					action = seq_pkg::act_a13;
			end
			seq_pkg::st_s6:
			begin
				next_state = cond_s[13] ? seq_pkg::st_s11 : seq_pkg::st_s12;
				action     = seq_pkg::act_a16;
			end
			seq_pkg::st_s7:
			begin
				next_state = seq_pkg::st_s13;
				action     = seq_pkg::act_a18;
			end
			seq_pkg::st_s8:
			begin
				next_state = seq_pkg::st_wrap;
				action     = seq_pkg::act_a8;
			end
			seq_pkg::st_s11:
			begin
				next_state = seq_pkg::st_s16;
				action     = seq_pkg::act_a17;
			end
			seq_pkg::st_s12:
			begin
				next_state = seq_pkg::st_s17;
				action     = seq_pkg::act_a17;
			end
			seq_pkg::st_s13:
			begin
				next_state = seq_pkg::st_s18;
				action     = seq_pkg::act_a17;
			end
			seq_pkg::st_s16:
			begin
				next_state = seq_pkg::st_s26;
				action     = seq_pkg::act_a19;
			end
			seq_pkg::st_s17:
			begin
				next_state = seq_pkg::st_s27;
				action     = seq_pkg::act_a19;
			end
			seq_pkg::st_s18:
			begin
				next_state = seq_pkg::st_wrap;
				action     = seq_pkg::act_a20;
			end
			seq_pkg::st_s24:
			begin
				next_state = seq_pkg::st_s7;
				action     = seq_pkg::act_a22;
			end
			seq_pkg::st_s26:
			begin
				if (cond_s[12])
				begin
					next_state = seq_pkg::st_wrap;
					action     = cond_s[13] ? seq_pkg::act_a23 : seq_pkg::act_a24;
				end
				else
				begin
					next_state = seq_pkg::st_s24;
					action     = seq_pkg::act_a21;
				end
			end
			seq_pkg::st_s27:
			begin
				if (cond_s[15] || cond_s[14])
				begin
					next_state = seq_pkg::st_s24;
					action     = seq_pkg::act_a21;
				end
				else
				begin
					next_state = seq_pkg::st_s7;
					action     = seq_pkg::act_a15;
				end
			end
			default:
				next_state = seq_pkg::st_idle;
		endcase
	end

	// the register never drifts into an encoding of a removed step
	state_legal: assert property (@(posedge rst) disable iff (!clk)
		state inside {seq_pkg::st_idle, seq_pkg::st_short, seq_pkg::st_prep,
			seq_pkg::st_dispatch, seq_pkg::st_wrap, seq_pkg::st_s6, seq_pkg::st_s7,
			seq_pkg::st_s8, seq_pkg::st_s11, seq_pkg::st_s12, seq_pkg::st_s13,
			seq_pkg::st_s16, seq_pkg::st_s17, seq_pkg::st_s18, seq_pkg::st_s24,
			seq_pkg::st_s26, seq_pkg::st_s27});

	short_to_idle: assert property (@(posedge rst) disable iff (!clk)
		state == seq_pkg::st_short |=> state == seq_pkg::st_idle);

endmodule

`default_nettype wire

// File: rtl/seq_pkg.sv
`default_nettype none

`include "seq_macros.svh"

package seq_pkg;

	typedef logic [`SEQ_COND_W:0] cond_t;

	typedef logic [`SEQ_CMD_W:0] cmd_t;

	// each encoding is the step number of its state
	typedef enum logic [4:0] {
		st_idle     = 5'd1,
		st_short    = 5'd2,
		st_prep     = 5'd3,
		st_dispatch = 5'd4,
		st_wrap     = 5'd5,
		st_s6       = 5'd6,
		st_s7       = 5'd7,
		st_s8       = 5'd8,
		st_s11      = 5'd11,
		st_s12      = 5'd12,
		st_s13      = 5'd13,
		st_s16      = 5'd16,
		st_s17      = 5'd17,
		st_s18      = 5'd18,
		st_s24      = 5'd24,
		st_s26      = 5'd26,
		st_s27      = 5'd27
	} state_e;

	// one code per distinct group of command lines
	typedef enum logic [4:0] {
		act_none,
		act_a1,  act_a2,  act_a3,  act_a4,  act_a5,
		act_a6,  act_a7,  act_a8,  act_a9,  act_a10,
		act_a11, act_a12, act_a13, act_a14, act_a15,
		act_a16, act_a17, act_a18, act_a19, act_a20,
		act_a21, act_a22, act_a23, act_a24
	} action_e;

endpackage

`default_nettype wire

// File: rtl/seq_top.sv
`timescale 1ns/1ns
`default_nettype none

module seq_top (
	input  logic           rst,
	input  logic           clk,
	input  seq_pkg::cond_t cond,
	output seq_pkg::cmd_t  cmd
);

	seq_pkg::cond_t   cond_s;
	seq_pkg::action_e action;

	cond_sync cond_sync_i (
		.rst    (rst),
		.clk    (clk),
		.cond   (cond),
		.cond_s (cond_s)
	);

	seq_controller seq_controller_i (
		.rst    (rst),
		.clk    (clk),
		.cond_s (cond_s),
		.action (action)
	);

	action_encoder action_encoder_i (
		.rst    (rst),
		.clk    (clk),
		.action (action),
		.cmd    (cmd)
	);

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/seq_pkg.sv
rtl/cond_sync.sv
rtl/dispatch_decoder.sv
rtl/seq_controller.sv
rtl/action_encoder.sv
rtl/seq_top.sv
testbench/tb_clock.sv
testbench/seq_ref_model.sv
testbench/tb_seq.sv

// File: testbench/seq_ref_model.sv
`timescale 1ns/1ns
`default_nettype none

module seq_ref_model (
	input  logic           rst,
	input  logic           clk,
	input  seq_pkg::cond_t cond,
	output seq_pkg::cmd_t  exp_cmd
);

	seq_pkg::cond_t stage1;
	seq_pkg::cond_t stage2;
	// step number of the current state with idle as step 1
	int             step;
	int             next_step;
	seq_pkg::cmd_t  lines;

	function automatic seq_pkg::cmd_t y(input int k);
		seq_pkg::cmd_t v;
		v    = '0;
		v[k] = 1'b1;
		return v;
	endfunction

	// decision tree of s4 where branches toward s9 and s10 come back as step 1
	function automatic int dispatch(input seq_pkg::cond_t x, output seq_pkg::cmd_t p);
		logic wrap;
		wrap = x[17] && (x[10] || x[11]);
		p    = '0;
		if (x[12])
		begin
			if (x[14])
			begin
				p = x[13] ? (x[16] ? y(25) : y(24)) : y(8);
				return x[13] ? 5 : 6;
			end
			if (x[15])
			begin
				if (x[13] && !x[16])
				begin
					p = y(2) | y(5) | y(6) | y(8) | y(11) | y(12) | y(21);
					return 7;
				end
				p = y(8);
				return 6;
			end
			if (x[13] && (x[16] ? x[11] : x[10]))
			begin
				p = y(20);
				return 8;
			end
			if (x[13])
			begin
				p = wrap ? y(28) : '0;
				return 1;
			end
			if (x[3])
			begin
				p = y(9) | y(35) | y(36);
				return 1;
			end
			if (x[16] && !x[1])
			begin
				p = y(8);
				return 6;
			end
			p = y(7) | y(8);
			return 1;
		end
		if (x[3])
			p = y(9) | y(35) | y(36);
		else if (!x[13] || (x[15] ? (x[16] || x[9]) : (x[16] ? x[8] : x[7])))
			p = y(7) | y(8);
		else if (wrap)
			p = y(28);
		return 1;
	endfunction

	function automatic int transition(input int s, input seq_pkg::cond_t x,
		output seq_pkg::cmd_t p);
		p = '0;
		case (s)
			1:
			begin
				if (x[6] && x[5])
					p = x[20] ? (x[19] ? y(17) | y(29) | y(34) : y(34)) : (x[19] ? y(39) : y(36));
				else if (x[6] && x[4])
				begin
					p = y(1) | y(17) | y(19) | y(29) | y(36);
					return 2;
				end
				else if (x[6])
				begin
					p = y(35) | y(37);
					return 3;
				end
				return 1;
			end
			2:
				p = y(1) | y(18) | y(25) | y(35) | y(38);
			3:
			begin
				p = y(20);
				return 4;
			end
			4:
				return dispatch(x, p);
			5:
				p = (x[17] && (x[10] || x[11])) ? y(28) : '0;
			6:
			begin
				p = y(5);
				return x[13] ? 11 : 12;
			end
			7:
			begin
				p = y(3) | y(26);
				return 13;
			end
			8:
			begin
				p = y(20);
				return 5;
			end
			// s11 to s13 lead to s16 to s18
			11, 12, 13:
			begin
				p = y(27);
				return s + 5;
			end
			16, 17:
			begin
				p = y(6);
				return s + 10;
			end
			18:
			begin
				p = y(10) | y(26);
				return 5;
			end
			24:
			begin
				p = y(2) | y(5) | y(6) | y(8) | y(10) | y(11) | y(12);
				return 7;
			end
			26:
			begin
				if (!x[12])
				begin
					p = y(13) | y(14) | y(15) | y(16);
					return 24;
				end
				p = x[13] ? y(22) | y(23) : y(1) | y(17);
				return 5;
			end
			27:
			begin
				if (x[15] || x[14])
				begin
					p = y(13) | y(14) | y(15) | y(16);
					return 24;
				end
				p = y(7) | y(8);
				return 7;
			end
			default:
				p = '0;
		endcase
		return 1;
	endfunction

	always @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			stage1  <= '0;
			stage2  <= '0;
			step    <= 1;
			exp_cmd <= '0;
		end
		else
		begin
			next_step = transition(step, stage2, lines);
			stage1  <= cond;
			stage2  <= stage1;
			step    <= next_step;
			exp_cmd <= lines;
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int half_period = 5
) (
	output logic rst
);

	initial
	begin
		rst = 1'b0;
		forever
			#half_period rst = ~rst;
	end

endmodule

`default_nettype wire

// File: testbench/tb_seq.sv
`timescale 1ns/1ns
`default_nettype none

module tb_seq;

	localparam int run_cycles    = 2000;
	localparam int reset_cycles  = 4;
	localparam int cycle_limit   = run_cycles + run_cycles / 10;
	// bit 0, y4 and y30 to y33
	localparam seq_pkg::cmd_t dropped_lines = 40'h03_c000_0011;

	logic           rst;
	logic           clk;
	seq_pkg::cond_t cond;
	seq_pkg::cmd_t  cmd;
	seq_pkg::cmd_t  exp_cmd;
	logic [15:0]    lfsr;
	int             cycle_count = 0;

	tb_clock clock_i (
		.rst (rst)
	);

	seq_top dut_i (
		.rst  (rst),
		.clk  (clk),
		.cond (cond),
		.cmd  (cmd)
	);

	seq_ref_model model_i (
		.rst     (rst),
		.clk     (clk),
		.cond    (cond),
		.exp_cmd (exp_cmd)
	);

	function automatic logic [15:0] galois_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic next_bit(output logic b);
		lfsr = galois_step(lfsr);
		b    = lfsr[0];
	endtask

	// every fourth cycle idle is pushed toward s2 or s3
	task automatic drive_random_cond(input int index);
		logic           b;
		seq_pkg::cond_t c;
		c = '0;
		for (int k = 1; k <= 20; k++)
		begin
			next_bit(b);
			c[k] = b;
		end
		if (index % 4 == 0)
		begin
			c[6] = 1'b1;
			c[5] = 1'b0;
			next_bit(b);
			if (b)
				c[4] = 1'b0;
		end
		cond = c;
	endtask

	task automatic check_cmd(input seq_pkg::cmd_t actual, input seq_pkg::cmd_t expected,
		input string what);
		if (actual !== expected)
		begin
			$display("FAIL at %0t ns: %s, cmd %h, expected %h", $time, what, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "command bus mismatch");
		end
	endtask

	always @(posedge rst)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		lfsr = 16'd4;
		clk  = 1'b0;
		cond = '0;
		repeat (reset_cycles)
		begin
			@(negedge rst);
			check_cmd(cmd, '0, "during reset");
		end
		@(posedge rst);
		#1;
		clk = 1'b1;
		@(posedge rst);
		@(negedge rst);
		check_cmd(cmd, '0, "first edge after reset");
		for (int i = 0; i < run_cycles; i++)
		begin
			@(posedge rst);
			#1;
			drive_random_cond(i);
			@(negedge rst);
			check_cmd(cmd & dropped_lines, '0, "dropped command lines");
			check_cmd(cmd, exp_cmd, "random run");
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
